// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_fma_row
FLIST     = flist.f
PASS_MSG  = PASS: all tests

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

clean:
	rm -rf obj_dir

// File: flist.f
src/fp16_pkg.sv
src/fma_pkg.sv
src/booth_multiplier.sv
src/align_add.sv
src/normalize_round.sv
src/fma_lane.sv
src/fma_row.sv
test/tb_fma_row.sv

// File: src/align_add.sv
// operand alignment and signed add
`timescale 1ns/10ps

module align_add (
    input  fma_pkg::mul_stage_t mul,
    output fma_pkg::add_stage_t sum
);

    localparam int W   = fma_pkg::SUM_W;
    localparam int LOW = W - 23;

    fp16_pkg::exp_t  exp_diff;
    logic            prod_big;
    logic [6:0]      shift;
    fma_pkg::prod_t  c_ext;
    fma_pkg::prod_t  big_x;
    fma_pkg::prod_t  small_x;
    logic [2*W-1:0]  small_full;
    fma_pkg::sum_t   big_win;
    fma_pkg::sum_t   small_win;
    logic            sticky;
    logic            sub;
    logic            big_sign;
    logic [W:0]      raw;
    logic            neg;

    // c on the product scale, hidden bit at weight 2^c_exp
    assign c_ext = {1'b0, mul.c_sig, 10'b0};

    assign exp_diff = mul.p_exp - mul.c_exp;
    assign prod_big = !exp_diff[6];
    assign shift    = prod_big ? exp_diff : -exp_diff;

    assign big_x    = prod_big ? mul.prod : c_ext;
    assign small_x  = prod_big ? c_ext : mul.prod;
    assign big_sign = prod_big ? mul.p_sign : mul.c_sign;

    assign big_win = {1'b0, big_x, {LOW{1'b0}}};

    // low half catches everything pushed out of the window
    assign small_full = {1'b0, small_x, {LOW{1'b0}}, {W{1'b0}}} >> shift;
    assign small_win  = small_full[2*W-1:W];
    assign sticky     = |small_full[W-1:0];

    assign sub = mul.p_sign ^ mul.c_sign;

    // with sticky set the lost bits are borrowed as one ulp,
    // sticky then stands for the positive remainder
    assign raw = sub ? {1'b0, big_win} - {1'b0, small_win} - {{W{1'b0}}, sticky}
                     : {1'b0, big_win} + {1'b0, small_win};
    assign neg = raw[W];

    assign sum.sign    = big_sign ^ neg;
    assign sum.ref_exp = prod_big ? mul.p_exp : mul.c_exp;
    assign sum.mag     = neg ? (~raw[W-1:0] + 1'b1) : raw[W-1:0];
    assign sum.sticky  = sticky;

endmodule

// File: src/booth_multiplier.sv
// radix-4 booth significand multiplier
`timescale 1ns/10ps

module booth_multiplier (
    input  fp16_pkg::sig_t sig_a,
    input  fp16_pkg::sig_t sig_b,
    output fma_pkg::prod_t product
);

    localparam int DIGITS   = 6;
    localparam int PP_W     = 24;
    localparam int MAX_PROD = 2047 * 2047;

    typedef logic [PP_W-1:0] pp_t;

    typedef struct packed {
        pp_t s;
        pp_t c;
    } csa_t;

    logic [12:0]           b_ext;
    fma_pkg::booth_digit_e digit [DIGITS];
    pp_t                   pp [DIGITS + 1];
    logic [11:0]           mult;
    logic                  neg;
    pp_t                   row;
    csa_t                  l1a, l1b, l2, l3, l4;

    // 3:2 compressor on full row width
    function automatic csa_t csa3(input pp_t x, input pp_t y, input pp_t z);
        csa_t r;
        r.s = x ^ y ^ z;
        r.c = ((x & y) | (y & z) | (x & z)) << 1;
        return r;
    endfunction

    // zero pad below and above, top digit stays positive
    assign b_ext = {1'b0, sig_b, 1'b0};

    always_comb begin
        for (int i = 0; i < DIGITS; i++) begin
            case (b_ext[2*i +: 3])
                3'b001, 3'b010: digit[i] = fma_pkg::BOOTH_P1;
                3'b011:         digit[i] = fma_pkg::BOOTH_P2;
                3'b100:         digit[i] = fma_pkg::BOOTH_M2;
                3'b101, 3'b110: digit[i] = fma_pkg::BOOTH_M1;
                default:        digit[i] = fma_pkg::BOOTH_ZERO;
            endcase
        end
    end

    // negative rows are inverted and sign extended
    // the missing +1 of each goes into the correction row
    always_comb begin
        pp[DIGITS] = '0;
        for (int i = 0; i < DIGITS; i++) begin
            mult = '0;
            neg  = 1'b0;
            case (digit[i])
                fma_pkg::BOOTH_P1: mult = {1'b0, sig_a};
                fma_pkg::BOOTH_P2: mult = {sig_a, 1'b0};
                fma_pkg::BOOTH_M1: begin
                    mult = {1'b0, sig_a};
                    neg  = 1'b1;
                end
                fma_pkg::BOOTH_M2: begin
                    mult = {sig_a, 1'b0};
                    neg  = 1'b1;
                end
                default: mult = '0;
            endcase
            row = {12'b0, mult};
            if (neg) begin
                row = ~row;
            end
            pp[i]          = row << (2 * i);
            pp[DIGITS][2*i] = neg;
        end
    end

    // seven rows down to two in four levels
    assign l1a = csa3(pp[0], pp[1], pp[2]);
    assign l1b = csa3(pp[3], pp[4], pp[5]);
    assign l2  = csa3(l1a.s, l1a.c, l1b.s);
    assign l3  = csa3(l2.s, l2.c, l1b.c);
    assign l4  = csa3(l3.s, l3.c, pp[DIGITS]);

    // sums are modulo 2^24, the true product fits in 22 bits
    assign product = fma_pkg::prod_t'(l4.s + l4.c);

    always_comb begin
        a_prod_max: assert final (32'(product) <= MAX_PROD)
            else $error("booth product %0d out of range", product);
    end

endmodule

// File: src/fma_lane.sv
// single fma lane, three stages
`timescale 1ns/10ps

module fma_lane (
    input  logic            clk,
    input  fp16_pkg::fp16_t a,
    input  fp16_pkg::fp16_t b,
    input  fp16_pkg::fp16_t c,
    output fp16_pkg::fp16_t result
);

    typedef struct packed {
        logic           sign;
        fp16_pkg::exp_t exp;
        fp16_pkg::sig_t sig;
    } operand_t;

    operand_t            op_a, op_b, op_c;
    fma_pkg::prod_t      prod;
    fma_pkg::mul_stage_t mul_d, mul_q;
    fma_pkg::add_stage_t add_d, add_q;
    fp16_pkg::fp16_t     res_d, res_q;

    // subnormals read as 2^-14 with no hidden bit
    function automatic operand_t unpack(input fp16_pkg::fp16_t x);
        operand_t             op;
        fp16_pkg::exp_field_t field;
        field   = x[14:10];
        op.sign = x[15];
        if (field == '0) begin
            op.exp = fp16_pkg::exp_t'(fp16_pkg::EXP_MIN);
            op.sig = {1'b0, x[9:0]};
        end else begin
            op.exp = fp16_pkg::exp_t'(field) - fp16_pkg::exp_t'(fp16_pkg::EXP_BIAS);
            op.sig = {1'b1, x[9:0]};
        end
        return op;
    endfunction

    assign op_a = unpack(a);
    assign op_b = unpack(b);
    assign op_c = unpack(c);

    booth_multiplier u_mul (
        .sig_a   (op_a.sig),
        .sig_b   (op_b.sig),
        .product (prod)
    );

    always_comb begin
        mul_d.p_sign = op_a.sign ^ op_b.sign;
        mul_d.p_exp  = op_a.exp + op_b.exp;
        mul_d.prod   = prod;
        mul_d.c_sign = op_c.sign;
        mul_d.c_exp  = op_c.exp;
        mul_d.c_sig  = op_c.sig;
    end

    align_add u_add (
        .mul (mul_q),
        .sum (add_d)
    );

    normalize_round u_norm (
        .sum    (add_q),
        .result (res_d)
    );

    // payload only, validity lives in the row
    always_ff @(posedge clk) begin
        mul_q <= mul_d;
        add_q <= add_d;
        res_q <= res_d;
    end

    assign result = res_q;

endmodule

// File: src/fma_pkg.sv
// fma datapath types
package fma_pkg;

    // exact 11x11 significand product
    typedef logic [21:0] prod_t;

    // adder window
    // larger operand sits just under a carry bit, 17 guard bits below it
    localparam int SUM_W = 40;
    typedef logic [SUM_W-1:0] sum_t;

    // stage 1 to stage 2
    typedef struct packed {
        logic           p_sign;
        fp16_pkg::exp_t p_exp;
        prod_t          prod;
        logic           c_sign;
        fp16_pkg::exp_t c_exp;
        fp16_pkg::sig_t c_sig;
    } mul_stage_t;

    // stage 2 to stage 3
    // ref_exp is the exponent of the larger operand in the window
    typedef struct packed {
        logic           sign;
        fp16_pkg::exp_t ref_exp;
        sum_t           mag;
        logic           sticky;
    } add_stage_t;

    // radix-4 booth selections
    typedef enum logic [2:0] {
        BOOTH_ZERO,
        BOOTH_P1,
        BOOTH_P2,
        BOOTH_M1,
        BOOTH_M2
    } booth_digit_e;

endpackage

// File: src/fma_row.sv
// fp16 fma row with credit flow control
`timescale 1ns/10ps

module fma_row #(
    parameter int LANES   = 4,
    parameter int CREDITS = 4
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              in_valid,
    output logic                              in_ready,
    input  fp16_pkg::fp16_t                   in_a,
    input  fp16_pkg::fp16_t [LANES-1:0]       in_b,
    input  fp16_pkg::fp16_t [LANES-1:0]       in_c,
    output logic                              out_valid,
    output fp16_pkg::fp16_t [LANES-1:0]       out_result,
    input  logic                              credit_return
);

    localparam int CNT_W = $clog2(CREDITS + 1);

    logic [CNT_W-1:0] credits;
    logic [2:0]       valid_sr;
    logic             accept;

    assign in_ready = (credits != '0);
    assign accept   = in_valid && in_ready;

    // a is broadcast to every lane
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        fma_lane u_lane (
            .clk    (clk),
            .a      (in_a),
            .b      (in_b[i]),
            .c      (in_c[i]),
            .result (out_result[i])
        );
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            credits  <= CNT_W'(CREDITS);
            valid_sr <= '0;
        end else begin
            credits  <= credits - CNT_W'(accept) + CNT_W'(credit_return);
            valid_sr <= {valid_sr[1:0], accept};
        end
    end

    // result shows in the third cycle after the accepting cycle
    assign out_valid = valid_sr[2];

    a_credit_max: assert property (@(posedge clk) disable iff (rst)
        credits <= CNT_W'(CREDITS))
        else $error("credit counter above %0d", CREDITS);

    // every row still in the pipe holds one taken credit
    a_no_accept_empty: assert property (@(posedge clk) disable iff (rst)
        $countones(valid_sr) <= CREDITS - int'(credits))
        else $error("row in flight without a taken credit");

    a_credit_overflow: assert property (@(posedge clk) disable iff (rst)
        credit_return |-> (credits < CNT_W'(CREDITS)) || accept)
        else $error("credit returned beyond the granted amount");

endmodule

// File: src/fp16_pkg.sv
// half-precision format types
package fp16_pkg;

    // raw storage word and its fields
    typedef logic [15:0] fp16_t;
    typedef logic [4:0]  exp_field_t;
    typedef logic [9:0]  frac_t;

    // significand with hidden bit
    typedef logic [10:0] sig_t;

    // true exponent, signed
    // covers product range -28..+30 plus normalization offsets
    typedef logic signed [6:0] exp_t;

    localparam int EXP_BIAS = 15;

    // smallest normal exponent, also used for subnormal inputs
    localparam int EXP_MIN = -14;

    // stored exponent of infinity
    localparam exp_field_t EXP_INF = 5'd31;

endpackage

// File: src/normalize_round.sv
// normalization, rounding and packing
`timescale 1ns/10ps

module normalize_round (
    input  fma_pkg::add_stage_t sum,
    output fp16_pkg::fp16_t     result
);

    localparam int W = fma_pkg::SUM_W;

    logic [5:0]          lz;
    fma_pkg::sum_t       norm;
    fp16_pkg::sig_t      sig;
    logic                guard;
    logic                rnd;
    logic                sticky;
    logic                round_up;
    logic [11:0]         sig_rnd;
    fp16_pkg::sig_t      sig_fin;
    fp16_pkg::frac_t     frac;
    logic signed [8:0]   exp_lead;
    logic signed [8:0]   exp_fin;

    // leading zero count, highest set bit wins
    always_comb begin
        lz = '0;
        for (int i = 0; i < W; i++) begin
            if (sum.mag[i]) begin
                lz = 6'(W - 1 - i);
            end
        end
    end

    assign norm = sum.mag << lz;

    assign sig    = norm[W-1:W-11];
    assign guard  = norm[W-12];
    assign rnd    = norm[W-13];
    assign sticky = (|norm[W-14:0]) | sum.sticky;

    // window bit 37 carries weight 2^ref_exp
    assign exp_lead = $signed({{2{sum.ref_exp[6]}}, sum.ref_exp}) + 9'sd2
                    - $signed({3'b000, lz});

    // nearest even
    assign round_up = guard & (rnd | sticky | sig[0]);
    assign sig_rnd  = {1'b0, sig} + {11'b0, round_up};

    // carry out leaves 1.000..0, one exponent up
    assign sig_fin = sig_rnd[11] ? sig_rnd[11:1] : sig_rnd[10:0];
    assign exp_fin = sig_rnd[11] ? exp_lead + 9'sd1 : exp_lead;
    assign frac    = sig_fin[9:0];

    always_comb begin
        if (sum.mag == '0) begin
            // exact cancellation gives +0
            result = 16'h0000;
        end else if (exp_fin < fp16_pkg::EXP_MIN) begin
            result = {sum.sign, 15'b0};
        end else if (exp_fin > fp16_pkg::EXP_BIAS) begin
            result = {sum.sign, fp16_pkg::EXP_INF, 10'b0};
        end else begin
            result = {sum.sign, 5'(exp_fin + fp16_pkg::EXP_BIAS), frac};
        end
    end

endmodule

// File: test/tb_fma_row.sv
// fma row testbench
`timescale 1ns/10ps

module tb_fma_row;

    localparam int LANES    = 4;
    localparam int CREDITS  = 4;
    localparam int LATENCY  = 3;
    localparam int WAIT_MAX = 100;

    typedef logic [LANES-1:0][15:0] row_t;

    logic                         clk;
    logic                         rst;
    logic                         in_valid;
    logic                         in_ready;
    fp16_pkg::fp16_t              in_a;
    fp16_pkg::fp16_t [LANES-1:0]  in_b;
    fp16_pkg::fp16_t [LANES-1:0]  in_c;
    logic                         out_valid;
    fp16_pkg::fp16_t [LANES-1:0]  out_result;
    logic                         credit_return = 1'b0;

    row_t  exp_q [$];
    int    cyc_q [$];
    int    cyc = 0;
    int    errors = 0;
    int    sb_errors = 0;
    int    rows_checked = 0;
    int    pending = 0;
    logic  hold = 1'b0;
    logic  timed_out = 1'b0;
    string names [6] = '{"reset values", "directed exact", "rounding and subnormal",
                         "range limits", "random full rate", "credit back-pressure"};

    fma_row #(
        .LANES   (LANES),
        .CREDITS (CREDITS)
    ) u_dut (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_a          (in_a),
        .in_b          (in_b),
        .in_c          (in_c),
        .out_valid     (out_valid),
        .out_result    (out_result),
        .credit_return (credit_return)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [10:0] sig_of(input logic [15:0] x);
        return (x[14:10] == 5'd0) ? {1'b0, x[9:0]} : {1'b1, x[9:0]};
    endfunction

    // subnormals sit at 2^-14
    function automatic int exp_of(input logic [15:0] x);
        return (x[14:10] == 5'd0) ? -14 : int'(x[14:10]) - 15;
    endfunction

    // exact a*b+c in units of 2^-48
    // rounded once at the end
    function automatic logic [15:0] fma_ref(input logic [15:0] a, input logic [15:0] b,
                                            input logic [15:0] c);
        int          k;
        int          sh;
        int          e;
        logic [95:0] p;
        logic [95:0] cv;
        logic [95:0] mag;
        logic [95:0] rem;
        logic [95:0] half;
        logic [11:0] sig;
        logic        ps;
        logic        sign;
        p  = 96'(sig_of(a)) * 96'(sig_of(b));
        p  = p << (exp_of(a) + exp_of(b) + 28);
        cv = 96'(sig_of(c)) << (exp_of(c) + 38);
        ps = a[15] ^ b[15];
        if (ps == c[15]) begin
            mag  = p + cv;
            sign = ps;
        end else if (p >= cv) begin
            mag  = p - cv;
            sign = ps;
        end else begin
            mag  = cv - p;
            sign = c[15];
        end
        if (mag == '0) begin
            return 16'h0000;
        end
        k = 0;
        for (int i = 0; i < 96; i++) begin
            if (mag[i]) begin
                k = i;
            end
        end
        if (k > 10) begin
            sh   = k - 10;
            sig  = 12'(mag >> sh);
            rem  = mag & ((96'd1 << sh) - 96'd1);
            half = 96'd1 << (sh - 1);
            if (rem > half || (rem == half && sig[0])) begin
                sig = sig + 12'd1;
            end
            if (sig[11]) begin
                sig = sig >> 1;
                k   = k + 1;
            end
        end else begin
            sig = 12'(mag << (10 - k));
        end
        e = k - 48;
        if (e < -14) begin
            return {sign, 15'b0};
        end
        if (e > 15) begin
            return {sign, 5'd31, 10'b0};
        end
        return {sign, 5'(e + 15), sig[9:0]};
    endfunction

    function automatic fp16_pkg::fp16_t rand_fp16();
        fp16_pkg::fp16_t x;
        x = 16'($urandom());
        // no inf or nan operands
        while (x[14:10] == 5'd31) begin
            x = 16'($urandom());
        end
        return x;
    endfunction

    // consumer and scoreboard
    always @(negedge clk) begin
        row_t exp_row;
        int   acc_cyc;
        credit_return = (pending > 0) && !hold;
        if (credit_return) begin
            pending = pending - 1;
        end
        if (out_valid === 1'b1) begin
            pending = pending + 1;
            if (exp_q.size() == 0) begin
                $display("output row at t=%0t has no accepted row behind it", $time);
                sb_errors = sb_errors + 1;
            end else begin
                exp_row = exp_q.pop_front();
                acc_cyc = cyc_q.pop_front();
                rows_checked = rows_checked + 1;
                if (cyc != acc_cyc + LATENCY) begin
                    $display("ERROR t=%0t: row came %0d cycles after acceptance, expected %0d",
                             $time, cyc - acc_cyc, LATENCY);
                    sb_errors = sb_errors + 1;
                end
                for (int i = 0; i < LANES; i++) begin
                    if (out_result[i] !== exp_row[i]) begin
                        $display("ERROR t=%0t: lane %0d result %h, expected %h",
                                 $time, i, out_result[i], exp_row[i]);
                        sb_errors = sb_errors + 1;
                    end
                end
            end
        end
    end

    task automatic record_accept(input fp16_pkg::fp16_t a, input row_t b, input row_t c);
        row_t exp_row;
        for (int i = 0; i < LANES; i++) begin
            exp_row[i] = fma_ref(a, b[i], c[i]);
        end
        exp_q.push_back(exp_row);
        cyc_q.push_back(cyc);
    endtask

    // called on a falling edge
    // in_valid stays high on return
    task automatic send_row(input fp16_pkg::fp16_t a, input row_t b, input row_t c);
        int n;
        in_a     = a;
        in_b     = b;
        in_c     = c;
        in_valid = 1'b1;
        n = 0;
        while (!in_ready && n < WAIT_MAX) begin
            @(negedge clk);
            n = n + 1;
        end
        if (!in_ready) begin
            $display("timeout: in_ready stayed low for %0d cycles", WAIT_MAX);
            timed_out = 1'b1;
        end else begin
            record_accept(a, b, c);
            @(negedge clk);
        end
    endtask

    // all rows out and all credits home
    task automatic drain();
        int n;
        in_valid = 1'b0;
        n = 0;
        while ((exp_q.size() != 0 || pending != 0) && n < WAIT_MAX) begin
            @(negedge clk);
            n = n + 1;
        end
        if (exp_q.size() != 0 || pending != 0) begin
            $display("timeout: %0d rows still expected after %0d cycles", exp_q.size(), n);
            timed_out = 1'b1;
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic check_ready(input logic want, input string where);
        if (in_ready !== want) begin
            $display("ERROR t=%0t: in_ready is %b %s, expected %b", $time, in_ready, where, want);
            errors = errors + 1;
        end
    endtask

    task automatic reset_state();
        check_ready(1'b1, "after reset");
        if (out_valid !== 1'b0) begin
            $display("ERROR t=%0t: out_valid is %b after reset, expected 0", $time, out_valid);
            errors = errors + 1;
        end
    endtask

    task automatic directed_rows();
        send_row(16'h3C00, {16'hC200, 16'h4000, 16'h3C00, 16'h3C00},
                 {16'hC200, 16'h4000, 16'h3C00, 16'h0000});
        send_row(16'h4000, {16'h4200, 16'h0000, 16'h4200, 16'h3C00},
                 {16'hC600, 16'h8000, 16'h3C00, 16'h0000});
        send_row(16'h0000, {16'h7BFF, 16'hC000, 16'h4200, 16'h3C00},
                 {16'h8000, 16'hB800, 16'h3C00, 16'h0000});
    endtask

    task automatic rounding_rows();
        // ties, near ties and a tie that carries into 2.0
        send_row(16'h3C00, {16'h1000, 16'h0FFF, 16'h1001, 16'h1000},
                 {16'h3FFF, 16'h3C00, 16'h3C00, 16'h3C00});
        send_row(16'h3C00, {16'h03FF, 16'h0001, 16'h9000, 16'h1000},
                 {16'h0001, 16'h0400, 16'h3C01, 16'h3C01});
        send_row(16'h0200, {16'h5800, 16'h7800, 16'h4000, 16'h3C00},
                 {16'h0200, 16'h0000, 16'h0000, 16'h8001});
    endtask

    task automatic range_rows();
        send_row(16'h7BFF, {16'hC000, 16'h4000, 16'h3C00, 16'h3C00},
                 {16'h0000, 16'h0000, 16'h4800, 16'h4C00});
        send_row(16'h0400, {16'h3800, 16'h3C00, 16'hB800, 16'h3800},
                 {16'h0200, 16'h8001, 16'h0000, 16'h0000});
        send_row(16'h0001, {16'h7800, 16'h3C00, 16'h8001, 16'h0001},
                 {16'h0000, 16'h0000, 16'h0000, 16'h0000});
    endtask

    task automatic random_rows();
        row_t b;
        row_t c;
        for (int r = 0; r < 300 && !timed_out; r++) begin
            for (int i = 0; i < LANES; i++) begin
                b[i] = rand_fp16();
                c[i] = rand_fp16();
            end
            send_row(rand_fp16(), b, c);
        end
    endtask

    task automatic backpressure_rows();
        @(posedge clk);
        hold = 1'b1;
        @(negedge clk);
        for (int r = 0; r < CREDITS && !timed_out; r++) begin
            check_ready(1'b1, "before the credits run out");
            send_row(16'h3C00 + 16'(r), 64'h4000_3C00_C000_3800, 64'h3C00_0000_B800_4200);
        end
        // one more row waits at the input while the pipe drains
        in_a     = 16'h4200;
        in_b     = 64'h3C00_3C00_3C00_3C00;
        in_c     = 64'h0000_3C00_C200_4000;
        in_valid = 1'b1;
        for (int n = 0; n < 6; n++) begin
            check_ready(1'b0, "with no credit left");
            @(negedge clk);
        end
        @(posedge clk);
        hold = 1'b0;
        @(negedge clk);
        check_ready(1'b0, "in the cycle the credit returns");
        @(negedge clk);
        check_ready(1'b1, "after a credit returned");
        if (in_ready) begin
            record_accept(in_a, in_b, in_c);
            @(negedge clk);
        end
    endtask

    initial begin
        int err_before;
        void'($urandom(32'hd4c4_08c6));
        rst      = 1'b1;
        in_valid = 1'b0;
        in_a     = '0;
        in_b     = '0;
        in_c     = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int t = 0; t < 6 && !timed_out; t++) begin
            err_before = errors + sb_errors;
            case (t)
                0: reset_state();
                1: directed_rows();
                2: rounding_rows();
                3: range_rows();
                4: random_rows();
                default: backpressure_rows();
            endcase
            if (!timed_out) begin
                drain();
            end
            $display("test %0d %s: done, %0d errors", t + 1, names[t],
                     errors + sb_errors - err_before);
        end
        $display("%0d rows checked, %0d errors", rows_checked, errors + sb_errors);
        if (errors + sb_errors == 0 && !timed_out) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
